//--- Bender.yml
package:
  name: multicycle_control

sources:
  - include_dirs:
      - design
    files:
      - design/cpuCtrlPkg.sv
      - design/instrDecoder.sv
      - design/ctrlSequencer.sv
      - design/ctrlWordGen.sv
      - design/multicycleControl.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/multicycleControl_assertions.sv
      - sim/multicycleControlTb.sv

//--- design/cpuCtrlPkg.sv
// Control unit package with instruction encodings, FSM states and control word types

`include "cpuCtrl_settings.svh"

package cpuCtrlPkg;

    typedef enum logic [`CTRL_OP_W-1:0] {
        opRType = 6'b000000,
        opAddi = 6'b001000,
        opAddiu = 6'b001001
    } opcode_e;

    typedef enum logic [`CTRL_FUNCT_W-1:0] {
        fnSll = 6'b000000,
        fnSrl = 6'b000010,
        fnSra = 6'b000011,
        fnSllv = 6'b000100,
        fnSrav = 6'b000111,
        fnAdd = 6'b100000,
        fnSub = 6'b100010,
        fnAnd = 6'b100100
    } funct_e;

    typedef enum logic [1:0] {classAluReg, classAluImm, classShift, classOpError} instrClass_e;

    typedef enum logic [2:0] {aluPass, aluAdd, aluSub, aluAnd} aluOp_e;

    typedef enum logic [2:0] {
        shiftIdle,
        shiftLoad,
        shiftLeft,
        shiftLogicRight,
        shiftArithRight
    } shiftOp_e;

    typedef enum logic [2:0] {
        stResetInit,
        stFetch,
        stDecode,
        stExecute,
        stOverflowExc,
        stOpErrorExc
    } ctrlState_e;

    typedef struct packed {
        shiftOp_e op;
    } shiftCtrl_t;

    typedef struct packed {
        instrClass_e instrClass;
        aluOp_e aluOp;
        logic immediate;
        logic checkOverflow;
        logic writeRd;
        shiftCtrl_t shift;
        logic variableAmt;
    } decodedInstr_t;

    typedef struct packed {
        logic [1:0] iorD;
        logic [1:0] writeRegSel;
        logic [1:0] aluSrcA;
        logic [1:0] aluSrcB;
        logic [1:0] pcSource;
        logic [2:0] writeDataSel;
        logic [1:0] shiftIn;
        logic [1:0] shiftAmt;
    } muxSel_t;

    typedef struct packed {
        logic pcWrite;
        logic loadAB;
        logic aluOutLoad;
        logic memRead;
        logic irWrite;
        logic regWrite;
        logic signExtend;
    } ctrlEnable_t;

    // Datapath mux encodings
    localparam logic [1:0] iorDPc = 2'b00;
    localparam logic [1:0] regSelRt = 2'b00;
    localparam logic [1:0] regSelRd = 2'b01;
    localparam logic [1:0] regSelStack = 2'b11;
    localparam logic [1:0] srcAPc = 2'b00;
    localparam logic [1:0] srcAReg = 2'b10;
    localparam logic [1:0] srcBReg = 2'b00;
    localparam logic [1:0] srcBFour = 2'b01;
    localparam logic [1:0] srcBImm = 2'b10;
    localparam logic [1:0] srcBBranchOff = 2'b11;
    localparam logic [1:0] pcSrcAluResult = 2'b00;
    localparam logic [2:0] dataSelAluOut = 3'b000;
    localparam logic [2:0] dataSelShifter = 3'b101;
    localparam logic [2:0] dataSelStackDefault = 3'b110;
    localparam logic [1:0] shiftInA = 2'b00;
    localparam logic [1:0] shiftInB = 2'b10;
    localparam logic [1:0] shiftAmtReg = 2'b00;
    localparam logic [1:0] shiftAmtShamt = 2'b01;

endpackage

//--- design/cpuCtrl_settings.svh
// Multicycle control unit settings for field widths and step counts

`ifndef CPU_CTRL_SETTINGS_SVH
`define CPU_CTRL_SETTINGS_SVH

// Instruction fields seen by the decoder
`define CTRL_OP_W 6
`define CTRL_FUNCT_W 6

// Step counter inside a state
// Wide enough for the longest state, which is fetch
`define CTRL_STEP_W 2

// Fetch cycles spent reading memory
// The cycle after them loads IR and PC
`define CTRL_FETCH_READS 3

`endif

//--- design/ctrlSequencer.sv
// Control sequencer FSM walking reset, fetch, decode, execute and exception steps

`timescale 1ns/10ps

`include "cpuCtrl_settings.svh"

module ctrlSequencer (
    input logic clk,
    input logic rst,
    input cpuCtrlPkg::decodedInstr_t decoded,
    input logic overflow,
    output cpuCtrlPkg::ctrlState_e state,
    output logic [`CTRL_STEP_W-1:0] step
);
    import cpuCtrlPkg::*;

    logic lastStep;
    logic overflowTrap;

    // Last step of the current state
    always_comb begin
        case (state)
            stFetch: lastStep = (step == `CTRL_STEP_W'(`CTRL_FETCH_READS));
            stDecode: lastStep = (step == `CTRL_STEP_W'(1));
            stExecute: begin
                if (decoded.instrClass == classShift) begin
                    lastStep = (step == `CTRL_STEP_W'(2));
                end else begin
                    lastStep = (step == `CTRL_STEP_W'(1));
                end
            end
            stOverflowExc: lastStep = (step == `CTRL_STEP_W'(1));
            default: lastStep = 1'b1;
        endcase
    end

    // ALU flag is valid while the result is being latched in execute step 0
    assign overflowTrap = (state == stExecute) && (decoded.instrClass != classShift) &&
        (step == '0) && decoded.checkOverflow && overflow;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stResetInit;
            step <= '0;
        end else if (overflowTrap) begin
            // Trap takes the place of the write-back cycle
            state <= stOverflowExc;
            step <= '0;
        end else if (!lastStep) begin
            step <= step + 1'b1;
        end else begin
            step <= '0;
            case (state)
                stFetch: state <= stDecode;
                stDecode: begin
                    if (decoded.instrClass == classOpError) begin
                        state <= stOpErrorExc;
                    end else begin
                        state <= stExecute;
                    end
                end
                default: state <= stFetch;
            endcase
        end
    end

endmodule

//--- design/ctrlWordGen.sv
// Control word generator driving datapath selects and enables from state and step

`timescale 1ns/10ps

`include "cpuCtrl_settings.svh"

module ctrlWordGen (
    input cpuCtrlPkg::ctrlState_e state,
    input logic [`CTRL_STEP_W-1:0] step,
    input cpuCtrlPkg::decodedInstr_t decoded,
    output cpuCtrlPkg::muxSel_t muxSel,
    output cpuCtrlPkg::ctrlEnable_t enables,
    output cpuCtrlPkg::aluOp_e aluOp,
    output cpuCtrlPkg::shiftOp_e shiftOp
);
    import cpuCtrlPkg::*;

    always_comb begin
        muxSel = '0;
        enables = '0;
        aluOp = aluPass;
        shiftOp = shiftIdle;

        case (state)
            // Stack pointer gets its default value
            stResetInit: begin
                muxSel.writeRegSel = regSelStack;
                muxSel.writeDataSel = dataSelStackDefault;
                enables.regWrite = 1'b1;
            end

            // PC + 4 stays on the ALU output for the whole fetch
            stFetch: begin
                muxSel.iorD = iorDPc;
                muxSel.aluSrcA = srcAPc;
                muxSel.aluSrcB = srcBFour;
                aluOp = aluAdd;
                if (step < `CTRL_STEP_W'(`CTRL_FETCH_READS)) begin
                    enables.memRead = 1'b1;
                end else begin
                    muxSel.pcSource = pcSrcAluResult;
                    enables.pcWrite = 1'b1;
                    enables.irWrite = 1'b1;
                end
            end

            stDecode: begin
                if (step == '0) begin
                    // Branch target into ALUOut ahead of need
                    muxSel.aluSrcA = srcAPc;
                    muxSel.aluSrcB = srcBBranchOff;
                    aluOp = aluAdd;
                    enables.aluOutLoad = 1'b1;
                end else begin
                    enables.loadAB = 1'b1;
                end
            end

            stExecute: begin
                if (decoded.instrClass == classShift) begin
                    muxSel.shiftIn = decoded.variableAmt ? shiftInA : shiftInB;
                    muxSel.shiftAmt = decoded.variableAmt ? shiftAmtReg : shiftAmtShamt;
                    case (step)
                        `CTRL_STEP_W'(0): shiftOp = shiftLoad;
                        `CTRL_STEP_W'(1): shiftOp = decoded.shift.op;
                        default: begin
                            muxSel.writeRegSel = decoded.writeRd ? regSelRd : regSelRt;
                            muxSel.writeDataSel = dataSelShifter;
                            enables.regWrite = 1'b1;
                        end
                    endcase
                end else begin
                    muxSel.aluSrcA = srcAReg;
                    muxSel.aluSrcB = decoded.immediate ? srcBImm : srcBReg;
                    aluOp = decoded.aluOp;
                    if (step == '0) begin
                        enables.aluOutLoad = 1'b1;
                        enables.signExtend = decoded.immediate;
                    end else begin
                        // Immediate forms write rt
                        muxSel.writeRegSel = decoded.writeRd ? regSelRd : regSelRt;
                        muxSel.writeDataSel = dataSelAluOut;
                        enables.regWrite = 1'b1;
                    end
                end
            end

            // Exception steps only return to fetch
            default: begin
                enables = '0;
            end
        endcase
    end

endmodule

//--- design/instrDecoder.sv
// Instruction decoder mapping opcode and funct to a class and its execute settings

`timescale 1ns/10ps

module instrDecoder (
    input cpuCtrlPkg::opcode_e op,
    input cpuCtrlPkg::funct_e funct,
    output cpuCtrlPkg::decodedInstr_t decoded
);
    import cpuCtrlPkg::*;

    always_comb begin
        decoded = '0;
        decoded.instrClass = classOpError;
        decoded.aluOp = aluPass;
        decoded.shift.op = shiftIdle;

        case (op)
            opRType: begin
                decoded.writeRd = 1'b1;
                case (funct)
                    fnAdd: begin
                        decoded.instrClass = classAluReg;
                        decoded.aluOp = aluAdd;
                        decoded.checkOverflow = 1'b1;
                    end
                    fnSub: begin
                        decoded.instrClass = classAluReg;
                        decoded.aluOp = aluSub;
                        decoded.checkOverflow = 1'b1;
                    end
                    fnAnd: begin
                        decoded.instrClass = classAluReg;
                        decoded.aluOp = aluAnd;
                    end
                    fnSll, fnSllv: begin
                        decoded.instrClass = classShift;
                        decoded.shift.op = shiftLeft;
                        decoded.variableAmt = (funct == fnSllv);
                    end
                    fnSra, fnSrav: begin
                        decoded.instrClass = classShift;
                        decoded.shift.op = shiftArithRight;
                        decoded.variableAmt = (funct == fnSrav);
                    end
                    fnSrl: begin
                        decoded.instrClass = classShift;
                        decoded.shift.op = shiftLogicRight;
                    end
                    default: begin
                        decoded.writeRd = 1'b0;
                    end
                endcase
            end
            opAddi: begin
                decoded.instrClass = classAluImm;
                decoded.aluOp = aluAdd;
                decoded.immediate = 1'b1;
                decoded.checkOverflow = 1'b1;
            end
            // addiu never traps
            opAddiu: begin
                decoded.instrClass = classAluImm;
                decoded.aluOp = aluAdd;
                decoded.immediate = 1'b1;
            end
            default: begin
                decoded.instrClass = classOpError;
            end
        endcase
    end

endmodule

//--- design/multicycleControl.sv
// Multicycle MIPS control unit top joining decoder, sequencer and control word generator

`timescale 1ns/10ps

`include "cpuCtrl_settings.svh"

module multicycleControl (
    input logic clk,
    input logic rst,
    input cpuCtrlPkg::opcode_e op,
    input cpuCtrlPkg::funct_e funct,
    input logic overflow,
    output cpuCtrlPkg::muxSel_t muxSel,
    output cpuCtrlPkg::ctrlEnable_t enables,
    output cpuCtrlPkg::aluOp_e aluOp,
    output cpuCtrlPkg::shiftOp_e shiftOp
);
    import cpuCtrlPkg::*;

    decodedInstr_t decoded;
    ctrlState_e state;
    logic [`CTRL_STEP_W-1:0] step;

    instrDecoder decoder (
        .op(op),
        .funct(funct),
        .decoded(decoded)
    );

    ctrlSequencer sequencer (
        .clk(clk),
        .rst(rst),
        .decoded(decoded),
        .overflow(overflow),
        .state(state),
        .step(step)
    );

    ctrlWordGen wordGen (
        .state(state),
        .step(step),
        .decoded(decoded),
        .muxSel(muxSel),
        .enables(enables),
        .aluOp(aluOp),
        .shiftOp(shiftOp)
    );

endmodule

//--- multicycleControl.f
+incdir+design
design/cpuCtrlPkg.sv
design/instrDecoder.sv
design/ctrlSequencer.sv
design/ctrlWordGen.sv
design/multicycleControl.sv
sim/multicycleControl_assertions.sv
sim/multicycleControlTb.sv

//--- sim/multicycleControlTb.sv
// Table-driven testbench running instructions through the multicycle control unit

`timescale 1ns/10ps

`include "cpuCtrl_settings.svh"

module multicycleControlTb;
    import cpuCtrlPkg::*;

    localparam int ClkPeriod = 20;
    localparam int NumRows = 16;
    localparam int MaxPeriod = 20;

    typedef struct packed {
        logic [5:0] op;
        logic [5:0] funct;
        logic overflow;
        logic [3:0] period;
        logic write;
        logic [1:0] regSel;
        logic [2:0] dataSel;
        aluOp_e aluOp;
        shiftOp_e shiftOp;
    } testRow_t;

    logic clk;
    logic rst;
    opcode_e op;
    funct_e funct;
    logic overflow;
    muxSel_t muxSel;
    ctrlEnable_t enables;
    aluOp_e aluOp;
    shiftOp_e shiftOp;

    testRow_t rows [NumRows];
    int errorCount = 0;
    int rowErrors = 0;

    multicycleControl dut (
        .clk(clk),
        .rst(rst),
        .op(op),
        .funct(funct),
        .overflow(overflow),
        .muxSel(muxSel),
        .enables(enables),
        .aluOp(aluOp),
        .shiftOp(shiftOp)
    );

    task automatic reportMismatch(input string name, input int got, input int expected);
        $display("CHECK FAILED at %0t ns: %s expected %0d got %0d", $time, name, expected, got);
        errorCount++;
        rowErrors++;
    endtask

    task automatic flagProblem(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        errorCount++;
        rowErrors++;
    endtask

    // Row columns are op, funct, overflow, period, write, regSel, dataSel, aluOp, shiftOp
    task automatic fillTable();
        rows[0] = '{opRType, fnAdd, 1'b0, 4'd8, 1'b1, regSelRd, dataSelAluOut, aluAdd, shiftIdle};
        rows[1] = '{opRType, fnAnd, 1'b0, 4'd8, 1'b1, regSelRd, dataSelAluOut, aluAnd, shiftIdle};
        rows[2] = '{opRType, fnSub, 1'b0, 4'd8, 1'b1, regSelRd, dataSelAluOut, aluSub, shiftIdle};
        rows[3] = '{opAddi, 6'h00, 1'b0, 4'd8, 1'b1, regSelRt, dataSelAluOut, aluAdd, shiftIdle};
        rows[4] = '{opAddiu, 6'h00, 1'b0, 4'd8, 1'b1, regSelRt, dataSelAluOut, aluAdd, shiftIdle};
        rows[5] = '{opRType, fnSll, 1'b0, 4'd9, 1'b1, regSelRd, dataSelShifter, aluPass, shiftLeft};
        rows[6] = '{opRType, fnSllv, 1'b0, 4'd9, 1'b1, regSelRd, dataSelShifter, aluPass, shiftLeft};
        rows[7] = '{opRType, fnSra, 1'b0, 4'd9, 1'b1, regSelRd, dataSelShifter, aluPass,
            shiftArithRight};
        rows[8] = '{opRType, fnSrav, 1'b0, 4'd9, 1'b1, regSelRd, dataSelShifter, aluPass,
            shiftArithRight};
        rows[9] = '{opRType, fnSrl, 1'b0, 4'd9, 1'b1, regSelRd, dataSelShifter, aluPass,
            shiftLogicRight};
        // Overflowing forms trap instead of writing back
        rows[10] = '{opRType, fnAdd, 1'b1, 4'd9, 1'b0, 2'b00, 3'b000, aluAdd, shiftIdle};
        rows[11] = '{opRType, fnSub, 1'b1, 4'd9, 1'b0, 2'b00, 3'b000, aluSub, shiftIdle};
        rows[12] = '{opAddi, 6'h00, 1'b1, 4'd9, 1'b0, 2'b00, 3'b000, aluAdd, shiftIdle};
        rows[13] = '{opAddiu, 6'h00, 1'b1, 4'd8, 1'b1, regSelRt, dataSelAluOut, aluAdd, shiftIdle};
        // lw and j are not kept
        rows[14] = '{6'h23, 6'h00, 1'b0, 4'd7, 1'b0, 2'b00, 3'b000, aluPass, shiftIdle};
        rows[15] = '{6'h02, 6'h00, 1'b0, 4'd7, 1'b0, 2'b00, 3'b000, aluPass, shiftIdle};
    endtask

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin : watchdog
        int totalCycles;
        #1;
        totalCycles = 0;
        foreach (rows[i]) begin
            totalCycles += rows[i].period;
        end
        #((totalCycles + 50) * ClkPeriod);
        $display("Watchdog expired after %0d cycles with instructions still running",
            totalCycles + 50);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int cycles;
        int writes;
        int memReads;
        int shiftCount;
        logic prevLoadAB;
        logic variableAmt;
        logic [1:0] seenRegSel;
        logic [1:0] seenAmt;
        logic [2:0] seenDataSel;
        aluOp_e execAluOp;
        shiftOp_e firstShift;
        shiftOp_e secondShift;

        rst = 1'b1;
        op = opRType;
        funct = fnAdd;
        overflow = 1'b0;
        fillTable();

        repeat (10) @(posedge clk);
        #2 rst = 1'b0;

        // Reset step and first fetch
        cycles = 0;
        writes = 0;
        memReads = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (enables.regWrite) begin
                writes++;
                if (muxSel.writeRegSel !== regSelStack)
                    reportMismatch("writeRegSel", muxSel.writeRegSel, regSelStack);
                if (muxSel.writeDataSel !== dataSelStackDefault)
                    reportMismatch("writeDataSel", muxSel.writeDataSel, dataSelStackDefault);
            end
            if (enables.memRead) memReads++;
        end while (!enables.irWrite && cycles < MaxPeriod);
        if (!enables.irWrite) flagProblem("first instruction fetch never loaded IR");
        if (writes != 1) reportMismatch("reset regWrite count", writes, 1);
        if (memReads != `CTRL_FETCH_READS)
            reportMismatch("memRead count", memReads, `CTRL_FETCH_READS);
        $display("Reset step: %0d errors", rowErrors);

        for (int i = 0; i < NumRows; i++) begin
            rowErrors = 0;
            // New instruction appears as IR loads
            @(posedge clk);
            #2;
            op = opcode_e'(rows[i].op);
            funct = funct_e'(rows[i].funct);
            overflow = rows[i].overflow;

            cycles = 0;
            writes = 0;
            memReads = 0;
            shiftCount = 0;
            prevLoadAB = 1'b0;
            seenRegSel = '0;
            seenDataSel = '0;
            seenAmt = '0;
            execAluOp = aluPass;
            firstShift = shiftIdle;
            secondShift = shiftIdle;
            do begin
                @(negedge clk);
                cycles++;
                if (prevLoadAB) execAluOp = aluOp;
                prevLoadAB = enables.loadAB;
                if (enables.regWrite) begin
                    writes++;
                    seenRegSel = muxSel.writeRegSel;
                    seenDataSel = muxSel.writeDataSel;
                end
                if (enables.memRead) memReads++;
                if (shiftOp != shiftIdle) begin
                    if (shiftCount == 0) begin
                        firstShift = shiftOp;
                    end else begin
                        secondShift = shiftOp;
                        seenAmt = muxSel.shiftAmt;
                    end
                    shiftCount++;
                end
            end while (!enables.irWrite && cycles < MaxPeriod);

            if (!enables.irWrite) flagProblem("no instruction fetch ended the period");
            if (!enables.pcWrite) flagProblem("IR loaded without a PC update");
            if (cycles != rows[i].period) reportMismatch("period", cycles, rows[i].period);
            if (memReads != `CTRL_FETCH_READS)
                reportMismatch("memRead count", memReads, `CTRL_FETCH_READS);
            if (execAluOp !== rows[i].aluOp) reportMismatch("aluOp", execAluOp, rows[i].aluOp);
            if (rows[i].write) begin
                if (writes != 1) reportMismatch("regWrite count", writes, 1);
                if (seenRegSel !== rows[i].regSel)
                    reportMismatch("writeRegSel", seenRegSel, rows[i].regSel);
                if (seenDataSel !== rows[i].dataSel)
                    reportMismatch("writeDataSel", seenDataSel, rows[i].dataSel);
            end else begin
                if (writes != 0) reportMismatch("regWrite count", writes, 0);
            end
            if (rows[i].shiftOp == shiftIdle) begin
                if (shiftCount != 0) reportMismatch("shift cycles", shiftCount, 0);
            end else begin
                // sllv and srav take the amount from rs
                variableAmt = (rows[i].op == opRType) &&
                    (rows[i].funct == fnSllv || rows[i].funct == fnSrav);
                if (shiftCount != 2) reportMismatch("shift cycles", shiftCount, 2);
                if (firstShift !== shiftLoad) reportMismatch("shiftOp", firstShift, shiftLoad);
                if (secondShift !== rows[i].shiftOp)
                    reportMismatch("shiftOp", secondShift, rows[i].shiftOp);
                if (seenAmt !== (variableAmt ? shiftAmtReg : shiftAmtShamt))
                    reportMismatch("shiftAmt", seenAmt,
                        variableAmt ? shiftAmtReg : shiftAmtShamt);
            end
            $display("Row %0d op=%h funct=%h overflow=%b period=%0d: %s", i, rows[i].op,
                rows[i].funct, rows[i].overflow, cycles, (rowErrors == 0) ? "ok" : "mismatch");
        end

        $display("Summary: %0d rows, %0d errors", NumRows, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- sim/multicycleControl_assertions.sv
// Bound checks on control word rules of the multicycle control unit

`timescale 1ns/10ps

module multicycleControlAssertions (
    input logic clk,
    input logic rst,
    input cpuCtrlPkg::ctrlEnable_t enables
);
    import cpuCtrlPkg::*;

    // IR and PC load in the same fetch cycle
    property pcWithIr;
        @(posedge clk) disable iff (rst) enables.pcWrite == enables.irWrite;
    endproperty

    property noReadDuringWrite;
        @(posedge clk) disable iff (rst) !(enables.memRead && enables.regWrite);
    endproperty

    // Decode starts with the branch target
    property decodeAfterFetch;
        @(posedge clk) disable iff (rst) enables.irWrite |=> enables.aluOutLoad;
    endproperty

    assert property (pcWithIr) else $error("pcWrite and irWrite differ");
    assert property (noReadDuringWrite) else $error("memRead and regWrite both high");
    assert property (decodeAfterFetch) else $error("No aluOutLoad after irWrite");

endmodule

bind multicycleControl multicycleControlAssertions controlRules (
    .clk(clk),
    .rst(rst),
    .enables(enables)
);
